// ==== ooo_core_backend.f ====
+incdir+verif
hdl/ooo_pkg.sv
hdl/dispatch_unit.sv
hdl/exec_lane.sv
hdl/completion_arbiter.sv
hdl/reorder_buffer.sv
hdl/ooo_core_backend.sv
verif/ooo_core_backend_tb.sv

// ==== Bender.yml ====
package:
  name: ooo_core_backend

sources:
  - files:
      - hdl/ooo_pkg.sv
      - hdl/dispatch_unit.sv
      - hdl/exec_lane.sv
      - hdl/completion_arbiter.sv
      - hdl/reorder_buffer.sv
      - hdl/ooo_core_backend.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/ooo_core_backend_tb.sv

// ==== verif/op_table.svh ====
// stimulus table for the back end testbench, one operation per row with its expected commit
// columns: opcode, dest areg, operand a, operand b, predicted_taken, result, mispredict

    localparam int num_ops     = 30;
    localparam int burst_first = 8;   // back to back, mostly mul
    localparam int burst_last  = 17;
    localparam int flush_first = 22;  // mispredicted branch with younger ops right behind
    localparam int flush_last  = 26;

    table_entry_t op_table [num_ops] = '{
        // independent alu ops
        {ooo_pkg::op_add, 5'd1,  32'h0000_0010, 32'h0000_0020, 1'b0, 32'h0000_0030, 1'b0},
        {ooo_pkg::op_sub, 5'd2,  32'h0000_0100, 32'h0000_0001, 1'b0, 32'h0000_00ff, 1'b0},
        {ooo_pkg::op_xor, 5'd3,  32'hf0f0_f0f0, 32'h0ff0_0ff0, 1'b0, 32'hff00_ff00, 1'b0},
        {ooo_pkg::op_sub, 5'd4,  32'h0000_0005, 32'h0000_0007, 1'b0, 32'hffff_fffe, 1'b0},
        {ooo_pkg::op_add, 5'd5,  32'hffff_ffff, 32'h0000_0002, 1'b0, 32'h0000_0001, 1'b0},
        // slow mul ahead of short ops
        {ooo_pkg::op_mul, 5'd6,  32'h0000_1234, 32'h0000_0010, 1'b0, 32'h0001_2340, 1'b0},
        {ooo_pkg::op_add, 5'd7,  32'h0000_0003, 32'h0000_0004, 1'b0, 32'h0000_0007, 1'b0},
        {ooo_pkg::op_xor, 5'd8,  32'haaaa_5555, 32'hffff_ffff, 1'b0, 32'h5555_aaaa, 1'b0},
        // burst
        {ooo_pkg::op_mul, 5'd9,  32'h0000_0003, 32'h0000_0005, 1'b0, 32'h0000_000f, 1'b0},
        {ooo_pkg::op_mul, 5'd10, 32'h0000_0100, 32'h0000_0100, 1'b0, 32'h0001_0000, 1'b0},
        {ooo_pkg::op_mul, 5'd11, 32'h0000_ffff, 32'h0000_ffff, 1'b0, 32'hfffe_0001, 1'b0},
        {ooo_pkg::op_mul, 5'd12, 32'h0001_0000, 32'h0001_0000, 1'b0, 32'h0000_0000, 1'b0},
        {ooo_pkg::op_add, 5'd13, 32'h0000_0001, 32'h0000_0001, 1'b0, 32'h0000_0002, 1'b0},
        {ooo_pkg::op_mul, 5'd14, 32'h0000_0007, 32'h0000_0009, 1'b0, 32'h0000_003f, 1'b0},
        {ooo_pkg::op_sub, 5'd15, 32'h0000_0000, 32'h0000_0001, 1'b0, 32'hffff_ffff, 1'b0},
        {ooo_pkg::op_mul, 5'd16, 32'h8000_0000, 32'h0000_0003, 1'b0, 32'h8000_0000, 1'b0},
        {ooo_pkg::op_xor, 5'd17, 32'h1234_5678, 32'h1234_5678, 1'b0, 32'h0000_0000, 1'b0},
        {ooo_pkg::op_mul, 5'd18, 32'h0000_000c, 32'h0000_000c, 1'b0, 32'h0000_0090, 1'b0},
        // branches predicted right
        {ooo_pkg::op_brc, 5'd19, 32'h0000_0005, 32'h0000_0005, 1'b1, 32'h0000_0001, 1'b0},
        {ooo_pkg::op_add, 5'd20, 32'h0000_0040, 32'h0000_0002, 1'b0, 32'h0000_0042, 1'b0},
        {ooo_pkg::op_brc, 5'd21, 32'h0000_0005, 32'h0000_0006, 1'b0, 32'h0000_0000, 1'b0},
        {ooo_pkg::op_sub, 5'd22, 32'h0000_0050, 32'h0000_0010, 1'b0, 32'h0000_0040, 1'b0},
        // taken branch predicted not taken
        {ooo_pkg::op_brc, 5'd23, 32'h0000_0009, 32'h0000_0009, 1'b0, 32'h0000_0001, 1'b1},
        {ooo_pkg::op_add, 5'd24, 32'h0000_0001, 32'h0000_0002, 1'b0, 32'h0000_0003, 1'b0},
        {ooo_pkg::op_add, 5'd25, 32'h0000_0010, 32'h0000_0010, 1'b0, 32'h0000_0020, 1'b0},
        {ooo_pkg::op_xor, 5'd26, 32'h0000_00ff, 32'h0000_000f, 1'b0, 32'h0000_00f0, 1'b0},
        {ooo_pkg::op_mul, 5'd27, 32'h0000_0011, 32'h0000_0011, 1'b0, 32'h0000_0121, 1'b0},
        // not taken branch predicted taken
        {ooo_pkg::op_brc, 5'd28, 32'h0000_0001, 32'h0000_0002, 1'b1, 32'h0000_0000, 1'b1},
        {ooo_pkg::op_sub, 5'd29, 32'h0000_1000, 32'h0000_0001, 1'b0, 32'h0000_0fff, 1'b0},
        {ooo_pkg::op_add, 5'd30, 32'h0000_0007, 32'h0000_0008, 1'b0, 32'h0000_000f, 1'b0}
    };

// ==== verif/ooo_core_backend_tb.sv ====
// drives the op table into the back end over req/ack and checks every commit in program order
`timescale 1ns/1ps

module ooo_core_backend_tb;

    localparam int timeout_cycles = 200;

    typedef struct packed {
        ooo_pkg::dispatch_op_t          op;
        logic [ooo_pkg::data_width-1:0] result;
        logic                           mispredict;
    } table_entry_t;

    typedef struct packed {
        logic [ooo_pkg::areg_width-1:0] areg;
        logic [ooo_pkg::data_width-1:0] value;
        logic                           mispredict;
    } commit_t;

    `include "op_table.svh"

    logic                           clock;
    logic                           reset;
    logic                           req;
    ooo_pkg::dispatch_op_t          op;
    logic                           ack;
    logic                           commit_valid;
    logic [ooo_pkg::areg_width-1:0] commit_areg;
    logic [ooo_pkg::data_width-1:0] commit_value;
    logic                           commit_mispredict;

    commit_t expected_q [$];  // acked, not yet committed
    int      cur_idx;         // table row on the intake
    int      errors;
    int      committed;
    int      discarded;
    logic    ack_prev;
    logic    drop_next_ack;

    ooo_core_backend #(.num_lanes(4), .rob_depth(8)) ooo_core_backend_i (
        .clock             (clock),
        .reset             (reset),
        .req               (req),
        .op                (op),
        .ack               (ack),
        .commit_valid      (commit_valid),
        .commit_areg       (commit_areg),
        .commit_value      (commit_value),
        .commit_mispredict (commit_mispredict)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference and reporting
    ////////////////////////////////////////////////////////////////////////////

    // brc is taken when a equals b
    function automatic commit_t lane_model(input ooo_pkg::dispatch_op_t d);
        commit_t c;
        logic    taken;
        taken        = (d.a == d.b);
        c.areg       = d.dest_areg;
        c.mispredict = 1'b0;
        case (d.opcode)
            ooo_pkg::op_add: c.value = d.a + d.b;
            ooo_pkg::op_sub: c.value = d.a - d.b;
            ooo_pkg::op_xor: c.value = d.a ^ d.b;
            ooo_pkg::op_mul: c.value = d.a * d.b;  // 32 bit context keeps the low half
            ooo_pkg::op_brc: begin
                c.value      = taken ? 32'd1 : 32'd0;
                c.mispredict = (taken != d.predicted_taken);
            end
            default: c.value = 'x;
        endcase
        return c;
    endfunction

    function automatic commit_t table_commit(input int idx);
        commit_t c;
        c.areg       = op_table[idx].op.dest_areg;
        c.value      = op_table[idx].result;
        c.mispredict = op_table[idx].mispredict;
        return c;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        errors++;
        $display("ERR %s expected 0x%0h actual 0x%0h", name, exp_val, act_val);
    endtask

    task automatic end_run;
        $display("errors %0d, committed %0d, discarded %0d", errors, committed, discarded);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // commit monitor
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_commit;
        commit_t exp_c;
        committed++;
        if (expected_q.size() == 0) begin
            errors++;
            $display("commit of areg %0d with no acked operation outstanding", commit_areg);
        end else begin
            exp_c = expected_q.pop_front();
            if (commit_areg !== exp_c.areg) begin
                report_mismatch("commit_areg", exp_c.areg, commit_areg);
            end
            if (commit_value !== exp_c.value) begin
                report_mismatch("commit_value", exp_c.value, commit_value);
            end
            if (commit_mispredict !== exp_c.mispredict) begin
                report_mismatch("commit_mispredict", exp_c.mispredict, commit_mispredict);
            end
        end
        // everything still queued is younger than the branch
        if (commit_mispredict === 1'b1) begin
            discarded += expected_q.size();
            expected_q.delete();
            drop_next_ack = 1'b1;
        end
    endtask

    always @(negedge clock) begin
        if (reset) begin
            ack_prev      = 1'b0;
            drop_next_ack = 1'b0;
        end else begin
            if (ack === 1'b1 && ack_prev !== 1'b1) begin
                if (drop_next_ack) begin
                    discarded++;  // issued in the commit cycle of the branch
                end else begin
                    expected_q.push_back(table_commit(cur_idx));
                end
            end
            ack_prev      = ack;
            drop_next_ack = 1'b0;
            if (commit_valid === 1'b1) begin
                check_commit();
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // intake driver
    ////////////////////////////////////////////////////////////////////////////

    function automatic bit back_to_back(input int idx);
        return (idx > burst_first && idx <= burst_last) || (idx > flush_first && idx <= flush_last);
    endfunction

    task automatic send_op(input int idx, output bit ok);
        int n;
        ok = 1'b0;
        @(posedge clock);
        cur_idx = idx;
        req     <= 1'b1;
        op      <= op_table[idx].op;  // held until the next request
        n = 0;
        @(negedge clock);
        while (ack !== 1'b1 && n < timeout_cycles) begin
            @(negedge clock);
            n++;
        end
        if (ack !== 1'b1) begin
            errors++;
            $display("timeout waiting for ack on table row %0d", idx);
        end else begin
            @(posedge clock);
            req <= 1'b0;
            n = 0;
            @(negedge clock);
            while (ack !== 1'b0 && n < timeout_cycles) begin
                @(negedge clock);
                n++;
            end
            if (ack !== 1'b0) begin
                errors++;
                $display("timeout with ack still high after req dropped on table row %0d", idx);
            end else begin
                ok = 1'b1;
            end
        end
    endtask

    initial begin
        int      gap;
        int      n;
        bit      sent_ok;
        commit_t model;
        void'($urandom(42319));
        errors    = 0;
        committed = 0;
        discarded = 0;
        cur_idx   = 0;
        reset     = 1'b1;
        req       = 1'b0;
        op        = '0;
        sent_ok   = 1'b1;

        // the table must agree with the lane rules
        for (int i = 0; i < num_ops; i++) begin
            model = lane_model(op_table[i].op);
            if (model.value !== op_table[i].result) begin
                report_mismatch($sformatf("op_table[%0d].result", i), model.value,
                                op_table[i].result);
            end
            if (model.mispredict !== op_table[i].mispredict) begin
                report_mismatch($sformatf("op_table[%0d].mispredict", i), model.mispredict,
                                op_table[i].mispredict);
            end
        end

        repeat (16) @(posedge clock);
        reset <= 1'b0;

        // quiet outputs before the first req
        for (int i = 0; i < 6; i++) begin
            @(negedge clock);
            if (ack !== 1'b0) begin
                report_mismatch("ack", 32'h0, ack);
            end
            if (commit_valid !== 1'b0) begin
                report_mismatch("commit_valid", 32'h0, commit_valid);
            end
        end

        for (int i = 0; i < num_ops && sent_ok; i++) begin
            gap = $urandom % 4;
            if (back_to_back(i)) begin
                gap = 0;
            end
            repeat (gap) @(posedge clock);
            send_op(i, sent_ok);
        end

        // drain the rob
        if (sent_ok) begin
            n = 0;
            while (expected_q.size() != 0 && n < timeout_cycles) begin
                @(negedge clock);
                n++;
            end
            if (expected_q.size() != 0) begin
                errors++;
                $display("timeout with %0d acked operations never committed",
                         expected_q.size());
            end else begin
                repeat (8) @(negedge clock);  // room for a stray commit
                if (committed + discarded != num_ops) begin
                    errors++;
                    $display("%0d operations sent but %0d committed and %0d discarded",
                             num_ops, committed, discarded);
                end
            end
        end
        end_run();
    end

endmodule

// ==== hdl/ooo_core_backend.sv ====
// back end top level, ties dispatch, the execution lanes, the arbiter and the rob together
`timescale 1ns/1ps

module ooo_core_backend #(
    parameter int num_lanes = 4,
    parameter int rob_depth = 8,  // power of two
    localparam int tag_width = $clog2(rob_depth),
    localparam int issue_width = $bits(ooo_pkg::dispatch_op_t) + tag_width,
    localparam int cpl_width = ooo_pkg::data_width + 1 + tag_width
) (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           req,
    input  ooo_pkg::dispatch_op_t          op,
    output logic                           ack,
    output logic                           commit_valid,
    output logic [ooo_pkg::areg_width-1:0] commit_areg,
    output logic [ooo_pkg::data_width-1:0] commit_value,
    output logic                           commit_mispredict
);

    logic                   flush;
    logic                   rob_full;
    logic                   alloc;
    logic [tag_width-1:0]   alloc_tag;
    logic [num_lanes-1:0]   lane_idle;
    logic [num_lanes-1:0]   issue_valid;
    logic [issue_width-1:0] issue;          // shared by all lanes
    logic [num_lanes-1:0]   lane_done;
    logic [cpl_width-1:0]   lane_cpl [num_lanes];
    logic [num_lanes-1:0]   grant;
    logic                   cpl_valid;
    logic [cpl_width-1:0]   cpl;

    dispatch_unit #(.num_lanes(num_lanes), .rob_depth(rob_depth)) dispatch_unit_i (
        .clock       (clock),
        .reset       (reset),
        .flush       (flush),
        .req         (req),
        .op          (op),
        .ack         (ack),
        .lane_idle   (lane_idle),
        .rob_full    (rob_full),
        .alloc_tag   (alloc_tag),
        .alloc       (alloc),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

    for (genvar g = 0; g < num_lanes; g++) begin : g_lane
        exec_lane #(.rob_depth(rob_depth)) exec_lane_i (
            .clock       (clock),
            .reset       (reset),
            .flush       (flush),
            .issue_valid (issue_valid[g]),
            .issue       (issue),
            .idle        (lane_idle[g]),
            .done        (lane_done[g]),
            .cpl         (lane_cpl[g]),
            .grant       (grant[g])
        );
    end

    completion_arbiter #(.num_lanes(num_lanes), .rob_depth(rob_depth)) completion_arbiter_i (
        .clock     (clock),
        .reset     (reset),
        .flush     (flush),
        .done      (lane_done),
        .lane_cpl  (lane_cpl),
        .grant     (grant),
        .cpl_valid (cpl_valid),
        .cpl       (cpl)
    );

    // op stays stable while req is high, so its areg is valid at alloc
    reorder_buffer #(.rob_depth(rob_depth)) reorder_buffer_i (
        .clock             (clock),
        .reset             (reset),
        .alloc             (alloc),
        .alloc_areg        (op.dest_areg),
        .alloc_tag         (alloc_tag),
        .rob_full          (rob_full),
        .cpl_valid         (cpl_valid),
        .cpl               (cpl),
        .commit_valid      (commit_valid),
        .commit_areg       (commit_areg),
        .commit_value      (commit_value),
        .commit_mispredict (commit_mispredict),
        .flush             (flush)
    );

endmodule

// ==== hdl/reorder_buffer.sv ====
// circular reorder buffer, retires completed ops in tag order and flushes on a mispredict
`timescale 1ns/1ps

module reorder_buffer #(
    parameter int rob_depth = 8,
    localparam int tag_width = $clog2(rob_depth),
    localparam int cpl_width = ooo_pkg::data_width + 1 + tag_width
) (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           alloc,
    input  logic [ooo_pkg::areg_width-1:0] alloc_areg,
    output logic [tag_width-1:0]           alloc_tag,
    output logic                           rob_full,
    input  logic                           cpl_valid,
    input  logic [cpl_width-1:0]           cpl,
    output logic                           commit_valid,
    output logic [ooo_pkg::areg_width-1:0] commit_areg,
    output logic [ooo_pkg::data_width-1:0] commit_value,
    output logic                           commit_mispredict,
    output logic                           flush
);

    typedef struct packed {
        logic [ooo_pkg::data_width-1:0] result;
        logic                           mispredict;
        logic [tag_width-1:0]           tag;
    } completion_t;

    completion_t cpl_in;

    ////////////////////////////////////////////////////////////////////////////
    // entries and pointers
    ////////////////////////////////////////////////////////////////////////////

    logic [ooo_pkg::areg_width-1:0] entry_areg       [rob_depth];
    logic [ooo_pkg::data_width-1:0] entry_value      [rob_depth];
    logic                           entry_mispredict [rob_depth];
    logic [rob_depth-1:0]           entry_done;

    // top bit of each pointer is the wrap bit
    logic [tag_width:0]   head;
    logic [tag_width:0]   tail;
    logic [tag_width-1:0] head_idx;
    logic                 empty;

    assign cpl_in    = cpl;
    assign head_idx  = head[tag_width-1:0];
    assign alloc_tag = tail[tag_width-1:0];

    // same slot, wrap bits equal when empty and different when full
    assign empty    = (head == tail);
    assign rob_full = (head[tag_width] != tail[tag_width]) && (head_idx == alloc_tag);

    ////////////////////////////////////////////////////////////////////////////
    // commit port
    ////////////////////////////////////////////////////////////////////////////

    // held off during flush, the head may already point past the branch
    assign commit_valid      = !empty && entry_done[head_idx] && !flush;
    assign commit_areg       = entry_areg[head_idx];
    assign commit_value      = entry_value[head_idx];
    assign commit_mispredict = entry_mispredict[head_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            flush <= 1'b0;
        end else begin
            flush <= commit_valid && commit_mispredict;  // one cycle after the branch
        end
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            head       <= '0;
            tail       <= '0;
            entry_done <= '0;  // drops every younger op
        end else begin
            if (alloc) begin
                tail                  <= tail + 1'b1;
                entry_done[alloc_tag] <= 1'b0;
            end
            if (cpl_valid) entry_done[cpl_in.tag] <= 1'b1;
            if (commit_valid) head <= head + 1'b1;
        end
    end

    // entry payload
    always_ff @(posedge clock) begin
        if (alloc) begin
            entry_areg[alloc_tag] <= alloc_areg;
        end
        if (cpl_valid) begin
            entry_value[cpl_in.tag]      <= cpl_in.result;
            entry_mispredict[cpl_in.tag] <= cpl_in.mispredict;
        end
    end

endmodule

// ==== hdl/completion_arbiter.sv ====
// round-robin pick of one finished lane per cycle, registered onto the completion bus
`timescale 1ns/1ps

module completion_arbiter #(
    parameter int num_lanes = 4,
    parameter int rob_depth = 8,
    localparam int tag_width = $clog2(rob_depth),
    localparam int cpl_width = ooo_pkg::data_width + 1 + tag_width
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 flush,
    input  logic [num_lanes-1:0] done,
    input  logic [cpl_width-1:0] lane_cpl [num_lanes],
    output logic [num_lanes-1:0] grant,
    output logic                 cpl_valid,
    output logic [cpl_width-1:0] cpl
);

    localparam int idx_width = (num_lanes > 1) ? $clog2(num_lanes) : 1;

    logic [idx_width-1:0] ptr;     // lane with top priority this cycle
    logic [idx_width-1:0] winner;
    logic                 found;

    // scan from ptr upward, wrapping around
    always_comb begin
        int k;
        found  = 1'b0;
        winner = ptr;
        for (int i = 0; i < num_lanes; i++) begin
            k = (int'(ptr) + i) % num_lanes;
            if (!found && done[k]) begin
                found  = 1'b1;
                winner = k[idx_width-1:0];
            end
        end
    end

    always_comb begin
        grant = '0;
        if (found) grant[winner] = 1'b1;  // lane drops done next cycle
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ptr       <= '0;
            cpl_valid <= 1'b0;
        end else begin
            cpl_valid <= found && !flush;  // nothing stale reaches the rob
            if (found) begin
                ptr <= (int'(winner) == num_lanes - 1) ? '0 : winner + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (found) cpl <= lane_cpl[winner];
    end

endmodule

// ==== hdl/exec_lane.sv ====
// one execution lane, computes an op over a fixed latency and holds the result until granted
`timescale 1ns/1ps

module exec_lane #(
    parameter int rob_depth = 8,
    localparam int tag_width = $clog2(rob_depth),
    localparam int issue_width = $bits(ooo_pkg::dispatch_op_t) + tag_width,
    localparam int cpl_width = ooo_pkg::data_width + 1 + tag_width
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   issue_valid,
    input  logic [issue_width-1:0] issue,
    output logic                   idle,
    output logic                   done,
    output logic [cpl_width-1:0]   cpl,
    input  logic                   grant
);

    localparam int cnt_width = $clog2(ooo_pkg::mul_latency + 1);

    typedef struct packed {
        ooo_pkg::dispatch_op_t op;
        logic [tag_width-1:0]  tag;
    } lane_issue_t;

    typedef struct packed {
        logic [ooo_pkg::data_width-1:0] result;
        logic                           mispredict;
        logic [tag_width-1:0]           tag;
    } completion_t;

    lane_issue_t                    issue_in;
    lane_issue_t                    held;       // operands of the op in flight
    logic                           busy;
    logic [cnt_width-1:0]           count;
    logic                           finish;
    logic                           taken;
    logic                           mispredict;
    logic [ooo_pkg::data_width-1:0] result;

    assign issue_in = issue;
    assign idle     = !busy;
    assign finish   = busy && !done && (count == 1);  // last latency cycle

    // datapath from the held operands
    always_comb begin
        taken      = (held.op.a == held.op.b);
        mispredict = 1'b0;
        case (held.op.opcode)
            ooo_pkg::op_add: result = held.op.a + held.op.b;
            ooo_pkg::op_sub: result = held.op.a - held.op.b;
            ooo_pkg::op_xor: result = held.op.a ^ held.op.b;
            ooo_pkg::op_mul: result = held.op.a * held.op.b;  // low half
            ooo_pkg::op_brc: begin
                result     = {{(ooo_pkg::data_width - 1){1'b0}}, taken};
                mispredict = (taken != held.op.predicted_taken);
            end
            default: result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else if (!busy) begin
            if (issue_valid) begin
                busy  <= 1'b1;
                count <= (issue_in.op.opcode == ooo_pkg::op_mul) ?
                         cnt_width'(ooo_pkg::mul_latency) : cnt_width'(ooo_pkg::alu_latency);
            end
        end else if (finish) begin
            done <= 1'b1;
        end else if (!done) begin
            count <= count - 1'b1;
        end else if (grant) begin
            busy <= 1'b0;  // idle from the next cycle
            done <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid && !busy) held <= issue_in;
        if (finish) cpl <= completion_t'{result: result, mispredict: mispredict, tag: held.tag};
    end

endmodule

// ==== hdl/dispatch_unit.sv ====
// dispatch stage, runs the four-phase req/ack intake and issues each op to an idle lane
`timescale 1ns/1ps

module dispatch_unit #(
    parameter int num_lanes = 4,
    parameter int rob_depth = 8,
    localparam int tag_width = $clog2(rob_depth),
    localparam int issue_width = $bits(ooo_pkg::dispatch_op_t) + tag_width
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   req,
    input  ooo_pkg::dispatch_op_t  op,
    output logic                   ack,
    input  logic [num_lanes-1:0]   lane_idle,
    input  logic                   rob_full,
    input  logic [tag_width-1:0]   alloc_tag,
    output logic                   alloc,
    output logic [num_lanes-1:0]   issue_valid,
    output logic [issue_width-1:0] issue
);

    localparam int lane_idx_width = (num_lanes > 1) ? $clog2(num_lanes) : 1;

    typedef struct packed {
        ooo_pkg::dispatch_op_t op;
        logic [tag_width-1:0]  tag;
    } lane_issue_t;

    typedef enum logic [1:0] {
        s_idle,          // ack low, waiting for req and resources
        s_acked,         // ack high until req drops
        s_wait_release   // ack just dropped
    } state_t;

    state_t                    state;
    logic                      any_idle;
    logic [lane_idx_width-1:0] lane_sel;
    logic                      do_issue;

    // lowest numbered idle lane wins
    always_comb begin
        any_idle = 1'b0;
        lane_sel = '0;
        for (int i = num_lanes - 1; i >= 0; i--) begin
            if (lane_idle[i]) begin
                any_idle = 1'b1;
                lane_sel = i[lane_idx_width-1:0];
            end
        end
    end

    // a flush cycle aborts the issue, the op is retried next cycle
    assign do_issue = (state == s_idle) && req && !rob_full && any_idle && !flush;
    assign alloc    = do_issue;
    assign ack      = (state == s_acked);
    assign issue    = lane_issue_t'{op: op, tag: alloc_tag};  // tail tag of the rob

    always_comb begin
        issue_valid = '0;
        if (do_issue) begin
            issue_valid[lane_sel] = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // handshake fsm
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= s_idle;
        end else begin
            case (state)
                s_idle:         if (do_issue) state <= s_acked;
                s_acked:        if (!req) state <= s_wait_release;
                s_wait_release: state <= s_idle;  // source sees ack low here
                default:        state <= s_idle;
            endcase
        end
    end

endmodule

// ==== hdl/ooo_pkg.sv ====
// shared widths, opcodes and the dispatch word, used by the back end RTL and its testbench
package ooo_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int data_width = 32;  // operands and results
    localparam int areg_width = 5;   // architectural register index

    // lane latency, counted from the first busy cycle to the cycle before done
    localparam int alu_latency = 1;
    localparam int mul_latency = 4;

    ////////////////////////////////////////////////////////////////////////////
    // operations
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_xor = 3'd2,
        op_mul = 3'd3,  // low half of the product
        op_brc = 3'd4   // branch compare, taken when a equals b
    } opcode_t;

    // one operation as it arrives on the intake handshake
    typedef struct packed {
        opcode_t                 opcode;
        logic [areg_width-1:0]   dest_areg;
        logic [data_width-1:0]   a;
        logic [data_width-1:0]   b;
        logic                    predicted_taken;  // only meaningful for op_brc
    } dispatch_op_t;

    // lane_issue_t and completion_t carry a tag whose width follows rob_depth,
    // so each module declares them locally with the tag as the last field:
    //   lane_issue_t  = { dispatch_op_t op, tag }
    //   completion_t  = { result, mispredict, tag }

endpackage
